//--- dataBus.f
+incdir+hdl
hdl/ks10Pkg.sv
hdl/vma.sv
hdl/ramfile.sv
hdl/dbm.sv
hdl/dbus.sv
hdl/dataBus.sv
verif/dataBusChecker.sv
verif/dataBusTb.sv

//--- hdl/dataBus.sv
`timescale 1ns/1ps

`include "ks10_defines.svh"

module dataBus
(
   input  logic                               clk,
   input  logic                               arstN,
   input  ks10Pkg::cromT                      crom,
   input  logic                               cacheHit,
   input  ks10Pkg::halfWordT                  pcFlags,
   input  ks10Pkg::halfWordT                  dp,
   input  ks10Pkg::halfWordT                  memData,
   input  ks10Pkg::halfWordT                  scad,
   input  ks10Pkg::halfWordT                  bytes,
   input  ks10Pkg::halfWordT                  exp,
   output ks10Pkg::halfWordT                  dbus,
   output logic [`KS10_VMA_MSB:`KS10_WORD_W-1] vmaAddr,
   output ks10Pkg::vmaFlagsT                  vmaFlags
);

   import ks10Pkg::*;

   // Ramfile read word
   halfWordT fmData;
   // DBM mux output
   halfWordT dbmWord;

   ////////////////////////////////////////////////////////////
   // Address register and fast memory
   ////////////////////////////////////////////////////////////

   vma i_vma
   (
      .clk      (clk),
      .arstN    (arstN),
      .crom     (crom),
      .dp       (dp),
      .vmaAddr  (vmaAddr),
      .vmaFlags (vmaFlags)
   );

   // Writes back from the bus
   ramfile i_ramfile
   (
      .clk     (clk),
      .arstN   (arstN),
      .crom    (crom),
      .vmaAddr (vmaAddr),
      .dbus    (dbus),
      .fmData  (fmData)
   );

   ////////////////////////////////////////////////////////////
   // Bus muxes
   ////////////////////////////////////////////////////////////

   dbm i_dbm
   (
      .crom     (crom),
      .scad     (scad),
      .bytes    (bytes),
      .exp      (exp),
      .dp       (dp),
      .memData  (memData),
      .vmaAddr  (vmaAddr),
      .vmaFlags (vmaFlags),
      .dbmWord  (dbmWord)
   );

   dbus i_dbus
   (
      .crom     (crom),
      .cacheHit (cacheHit),
      .vmaAddr  (vmaAddr),
      .vmaFlags (vmaFlags),
      .pcFlags  (pcFlags),
      .dp       (dp),
      .fmData   (fmData),
      .dbmWord  (dbmWord),
      .dbus     (dbus)
   );

endmodule

//--- hdl/dbm.sv
`timescale 1ns/1ps

`include "ks10_defines.svh"

module dbm
(
   input  ks10Pkg::cromT                      crom,
   input  ks10Pkg::halfWordT                  scad,
   input  ks10Pkg::halfWordT                  bytes,
   input  ks10Pkg::halfWordT                  exp,
   input  ks10Pkg::halfWordT                  dp,
   input  ks10Pkg::halfWordT                  memData,
   input  logic [`KS10_VMA_MSB:`KS10_WORD_W-1] vmaAddr,
   input  ks10Pkg::vmaFlagsT                  vmaFlags,
   output ks10Pkg::halfWordT                  dbmWord
);

   ////////////////////////////////////////////////////////////
   // DBM source selection
   ////////////////////////////////////////////////////////////

   // Eight-way word mux feeding the DBUS
   // Purely combinational, no state
   always_comb
   begin
      case (crom.dbmSel)
         `KS10_DBM_SEL_SCADPFAR:
         begin
            // SCAD in the left half
            dbmWord.half.lh = scad.half.lh;
            // Page fail address, low 18 bits of the VMA
            dbmWord.half.rh = vmaAddr[`KS10_WORD_W-`KS10_HALF_W:`KS10_WORD_W-1];
         end
         `KS10_DBM_SEL_BYTES:
         begin
            dbmWord = bytes;
         end
         `KS10_DBM_SEL_EXP:
         begin
            dbmWord = exp;
         end
         `KS10_DBM_SEL_DP:
         begin
            dbmWord = dp;
         end
         `KS10_DBM_SEL_DPSWAP:
         begin
            // Halves exchanged
            dbmWord.half.lh = dp.half.rh;
            dbmWord.half.rh = dp.half.lh;
         end
         `KS10_DBM_SEL_VMA:
         begin
            // 14 flag bits then the 22-bit address
            dbmWord.word = {vmaFlags, vmaAddr};
         end
         `KS10_DBM_SEL_MEM:
         begin
            // Main memory read data
            dbmWord = memData;
         end
         `KS10_DBM_SEL_NUM:
         begin
            // Number field in both halves
            dbmWord.half.lh = crom.number;
            dbmWord.half.rh = crom.number;
         end
         default:
         begin
            dbmWord = dp;
         end
      endcase
   end

endmodule

//--- hdl/dbus.sv
`timescale 1ns/1ps

`include "ks10_defines.svh"

module dbus
(
   input  ks10Pkg::cromT                      crom,
   input  logic                               cacheHit,
   input  logic [`KS10_VMA_MSB:`KS10_WORD_W-1] vmaAddr,
   input  ks10Pkg::vmaFlagsT                  vmaFlags,
   input  ks10Pkg::halfWordT                  pcFlags,
   input  ks10Pkg::halfWordT                  dp,
   input  ks10Pkg::halfWordT                  fmData,
   input  ks10Pkg::halfWordT                  dbmWord,
   output ks10Pkg::halfWordT                  dbus
);

   ////////////////////////////////////////////////////////////
   // Ramfile override
   ////////////////////////////////////////////////////////////

   logic acRef;
   logic acRefForce;
   logic cacheForce;
   logic forceRamfile;

   // AC reference
   // Lowest 16 addresses, never a physical access
   assign acRef = ~vmaFlags.physical &
                  (vmaAddr[`KS10_ACREF_MSB:`KS10_ACREF_LSB] == '0);

   // AC reads come from the ramfile
   // Except at the one excluded microaddress
   assign acRefForce = acRef & vmaFlags.readCycle &
                       (crom.microAddr != `KS10_ACREF_EXCL_ADDR);

   // Cache hit on a read also goes to the ramfile
   assign cacheForce = cacheHit & vmaFlags.readCycle;

   assign forceRamfile = acRefForce | cacheForce;

   ////////////////////////////////////////////////////////////
   // Bus mux
   ////////////////////////////////////////////////////////////

   // Four-way select, DBM may be replaced by the ramfile
   always_comb
   begin
      case (crom.dbusSel)
         `KS10_DBUS_SEL_FLAGS:
         begin
            // PC flags sit in the left half
            dbus = pcFlags;
         end
         `KS10_DBUS_SEL_DP:
         begin
            dbus = dp;
         end
         `KS10_DBUS_SEL_RAMFILE:
         begin
            dbus = fmData;
         end
         `KS10_DBUS_SEL_DBM:
         begin
            if (forceRamfile)
            begin
               dbus = fmData;
            end
            else
            begin
               dbus = dbmWord;
            end
         end
         default:
         begin
            dbus = dp;
         end
      endcase
   end

endmodule

//--- hdl/ks10Pkg.sv
`include "ks10_defines.svh"

package ks10Pkg;

   ////////////////////////////////////////////////////////////
   // Word types
   ////////////////////////////////////////////////////////////

   // Left and right halves, left half is the high end
   typedef struct packed
   {
      logic [0:`KS10_HALF_W-1] lh;
      logic [0:`KS10_HALF_W-1] rh;
   } halvesT;

   // One 36-bit word, seen whole or as two halves
   typedef union packed
   {
      logic [0:`KS10_WORD_W-1] word;
      halvesT                  half;
   } halfWordT;

   ////////////////////////////////////////////////////////////
   // VMA flags, bits 0 to 13 of the flag field
   ////////////////////////////////////////////////////////////

   typedef struct packed
   {
      logic       user;         // Bit 0
      logic       rsvd1;
      logic       fetch;        // Bit 2
      logic       readCycle;    // Bit 3
      logic       writeTest;    // Bit 4
      logic       writeCycle;   // Bit 5
      logic [1:0] rsvd6;        // Bits 6 and 7
      logic       physical;     // Bit 8
      logic [4:0] rsvd9;        // Bits 9 to 13
   } vmaFlagsT;

   ////////////////////////////////////////////////////////////
   // Control microword, only the data bus path fields
   ////////////////////////////////////////////////////////////

   typedef struct packed
   {
      logic [0:11]             microAddr;   // Address of this word
      logic [1:0]              dbusSel;
      logic [2:0]              dbmSel;
      logic                    loadVma;     // VMA load strobe
      vmaFlagsT                vmaFlagsIn;  // Flags for the VMA load
      logic                    fmWrite;     // Ramfile write strobe
      logic                    fmAddrSel;   // 0 AC number, 1 VMA
      logic [2:0]              acBlock;
      logic [3:0]              acNum;
      logic [0:`KS10_HALF_W-1] number;      // Number field
   } cromT;

endpackage

//--- hdl/ks10_defines.svh
`ifndef KS10_DEFINES_SVH
`define KS10_DEFINES_SVH

// Machine word and half word, bit 0 is the MSB
`define KS10_WORD_W 36
`define KS10_HALF_W 18

// VMA address occupies word bits 14 to 35
`define KS10_VMA_MSB 14

// Address bits that must be zero for an AC reference
`define KS10_ACREF_MSB 18
`define KS10_ACREF_LSB 31

// Fast memory geometry
`define KS10_FM_DEPTH  1024
`define KS10_FM_ADDR_W 10

// DBUS select codes
`define KS10_DBUS_SEL_FLAGS   2'd0
`define KS10_DBUS_SEL_DP      2'd1
`define KS10_DBUS_SEL_RAMFILE 2'd2
`define KS10_DBUS_SEL_DBM     2'd3

// DBM select codes
`define KS10_DBM_SEL_SCADPFAR 3'd0
`define KS10_DBM_SEL_BYTES    3'd1
`define KS10_DBM_SEL_EXP      3'd2
`define KS10_DBM_SEL_DP       3'd3
`define KS10_DBM_SEL_DPSWAP   3'd4
`define KS10_DBM_SEL_VMA      3'd5
`define KS10_DBM_SEL_MEM      3'd6
`define KS10_DBM_SEL_NUM      3'd7

// Microaddress where an AC reference must not force the ramfile
`define KS10_ACREF_EXCL_ADDR 12'o1146

`endif

//--- hdl/ramfile.sv
`timescale 1ns/1ps

`include "ks10_defines.svh"

module ramfile
(
   input  logic                               clk,
   input  logic                               arstN,
   input  ks10Pkg::cromT                      crom,
   input  logic [`KS10_VMA_MSB:`KS10_WORD_W-1] vmaAddr,
   input  ks10Pkg::halfWordT                  dbus,
   output ks10Pkg::halfWordT                  fmData
);

   import ks10Pkg::*;

   // Fast memory array
   halfWordT mem [0:`KS10_FM_DEPTH-1];

   logic [0:`KS10_FM_ADDR_W-1] fmAddr;

   // Posted write, last written address and word
   logic                       lastWrValid;
   logic [0:`KS10_FM_ADDR_W-1] lastWrAddr;
   halfWordT                   lastWrData;

   logic                       hitLastWr;

   ////////////////////////////////////////////////////////////
   // Address select
   ////////////////////////////////////////////////////////////

   // AC block, three zero bits, AC number
   // Or the low 10 bits of the VMA
   always_comb
   begin
      if (crom.fmAddrSel)
      begin
         fmAddr = vmaAddr[`KS10_WORD_W-`KS10_FM_ADDR_W:`KS10_WORD_W-1];
      end
      else
      begin
         fmAddr = {crom.acBlock, 3'b000, crom.acNum};
      end
   end

   ////////////////////////////////////////////////////////////
   // Write path
   ////////////////////////////////////////////////////////////

   // Capture address on the write strobe
   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         lastWrValid <= 1'b0;
         lastWrAddr  <= '0;
      end
      else
      begin
         lastWrValid <= crom.fmWrite;
         if (crom.fmWrite)
         begin
            lastWrAddr <= fmAddr;
         end
      end
   end

   // Bus word held with the address
   always_ff @(posedge clk)
   begin
      if (crom.fmWrite)
      begin
         lastWrData <= dbus;
      end
   end

   // Array updated one cycle later from the holding register
   always_ff @(posedge clk)
   begin
      if (lastWrValid)
      begin
         mem[lastWrAddr] <= lastWrData;
      end
   end

   ////////////////////////////////////////////////////////////
   // Read path
   ////////////////////////////////////////////////////////////

   // Bypass while the newest write is still posted
   assign hitLastWr = lastWrValid & (lastWrAddr == fmAddr);

   assign fmData = hitLastWr ? lastWrData : mem[fmAddr];

endmodule

//--- hdl/vma.sv
`timescale 1ns/1ps

`include "ks10_defines.svh"

module vma
(
   input  logic                               clk,
   input  logic                               arstN,
   input  ks10Pkg::cromT                      crom,
   input  ks10Pkg::halfWordT                  dp,
   output logic [`KS10_VMA_MSB:`KS10_WORD_W-1] vmaAddr,
   output ks10Pkg::vmaFlagsT                  vmaFlags
);

   ////////////////////////////////////////////////////////////
   // Virtual memory address register
   ////////////////////////////////////////////////////////////

   // Address from the right 22 bits of the datapath
   // Flags straight from the microword
   // Outputs change on the edge after the strobe
   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         // No read cycle pending out of reset
         vmaAddr  <= '0;
         vmaFlags <= '0;
      end
      else if (crom.loadVma)
      begin
         vmaAddr  <= dp.word[`KS10_VMA_MSB:`KS10_WORD_W-1];
         vmaFlags <= crom.vmaFlagsIn;
      end
   end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the data bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dataBusTb -f dataBus.f
if [ $? -ne 0 ]; then
   echo "Compile failed"
   exit 1
fi

out=$(./obj_dir/VdataBusTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "All tests passed"; then
   exit 0
fi
exit 1

//--- verif/dataBusChecker.sv
`timescale 1ns/1ps

`include "ks10_defines.svh"

module dataBusChecker
(
   input  logic                               clk,
   input  logic                               arstN,
   input  ks10Pkg::cromT                      crom,
   input  logic [`KS10_VMA_MSB:`KS10_WORD_W-1] vmaAddr,
   input  ks10Pkg::vmaFlagsT                  vmaFlags,
   input  ks10Pkg::halfWordT                  dbus,
   input  ks10Pkg::halfWordT                  fmData
);

   import ks10Pkg::*;

   // Ramfile address seen by the read port
   logic [0:`KS10_FM_ADDR_W-1] curAddr;

   // Most recent write
   logic                       wrSeen;
   logic [0:`KS10_FM_ADDR_W-1] wrAddr;
   halfWordT                   wrWord;

   assign curAddr = crom.fmAddrSel ? vmaAddr[`KS10_WORD_W-`KS10_FM_ADDR_W:`KS10_WORD_W-1]
                                   : {crom.acBlock, 3'b000, crom.acNum};

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         wrSeen <= 1'b0;
         wrAddr <= '0;
         wrWord <= '0;
      end
      else if (crom.fmWrite)
      begin
         wrSeen <= 1'b1;
         wrAddr <= curAddr;
         wrWord <= dbus;
      end
   end

   ////////////////////////////////////////////////////////////
   // Properties
   ////////////////////////////////////////////////////////////

   // No pending read cycle out of reset
   assert property (@(posedge clk) !arstN |-> vmaFlags == '0)
      else $error("VMA flags not clear during reset");

   // VMA only moves on its strobe
   assert property (@(posedge clk) disable iff (!arstN)
                    !crom.loadVma |=> ($stable(vmaAddr) && $stable(vmaFlags)))
      else $error("VMA changed without loadVma");

   // Read after write returns the bus word
   assert property (@(posedge clk) disable iff (!arstN)
                    (wrSeen && curAddr == wrAddr) |-> fmData == wrWord)
      else $error("Ramfile read differs from last written word");

endmodule

bind dataBus dataBusChecker i_checker
(
   .clk      (clk),
   .arstN    (arstN),
   .crom     (crom),
   .vmaAddr  (vmaAddr),
   .vmaFlags (vmaFlags),
   .dbus     (dbus),
   .fmData   (fmData)
);

//--- verif/dataBusTb.sv
`timescale 1ns/1ps

`include "ks10_defines.svh"

module dataBusTb;

   import ks10Pkg::*;

   // Watchdog budget, about 110 cycles of tests
   localparam int clkPeriod  = 4;
   localparam int testCycles = 150;
   localparam int marginNs   = 100;

   logic     clk;
   logic     arstN;
   cromT     crom;
   logic     cacheHit;
   halfWordT pcFlags;
   halfWordT dp;
   halfWordT memData;
   halfWordT scad;
   halfWordT bytes;
   halfWordT exp;
   halfWordT dbus;
   logic [`KS10_VMA_MSB:`KS10_WORD_W-1] vmaAddr;
   vmaFlagsT vmaFlags;

   integer seed = 60100;
   int     errors = 0;

   dataBus i_dut
   (
      .clk      (clk),
      .arstN    (arstN),
      .crom     (crom),
      .cacheHit (cacheHit),
      .pcFlags  (pcFlags),
      .dp       (dp),
      .memData  (memData),
      .scad     (scad),
      .bytes    (bytes),
      .exp      (exp),
      .dbus     (dbus),
      .vmaAddr  (vmaAddr),
      .vmaFlags (vmaFlags)
   );

   initial
   begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   function automatic logic [0:35] randWord();
      logic [63:0] r;
      r = {$random(seed), $random(seed)};
      return r[35:0];
   endfunction

   task automatic checkWord(input string name, input logic [0:35] expv,
                            input logic [0:35] actv);
      if (actv !== expv)
      begin
         errors++;
         $display("FAILED %s expected %012o actual %012o", name, expv, actv);
      end
   endtask

   // One-cycle VMA load strobe
   task automatic loadVmaReg(input logic [14:35] addr, input vmaFlagsT flags);
      @(negedge clk);
      dp.word = randWord();
      dp.word[14:35] = addr;
      crom.vmaFlagsIn = flags;
      crom.loadVma = 1'b1;
      @(negedge clk);
      crom.loadVma = 1'b0;
   endtask

   // Bus carries dp, written at AC block and number
   task automatic writeFm(input logic [2:0] blk, input logic [3:0] num,
                          input logic [0:35] word);
      @(negedge clk);
      crom.dbusSel = `KS10_DBUS_SEL_DP;
      crom.fmAddrSel = 1'b0;
      crom.acBlock = blk;
      crom.acNum = num;
      dp.word = word;
      crom.fmWrite = 1'b1;
      @(negedge clk);
      crom.fmWrite = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////

   task automatic testResetSelects();
      checkWord("reset vmaAddr", 36'd0, {14'd0, vmaAddr});
      checkWord("reset vmaFlags", 36'd0, {22'd0, vmaFlags});
      for (int i = 0; i < 8; i++)
      begin
         @(negedge clk);
         pcFlags.word = randWord();
         dp.word = randWord();
         crom.dbusSel = `KS10_DBUS_SEL_FLAGS;
         #1;
         checkWord("select flags", pcFlags.word, dbus.word);
         @(negedge clk);
         crom.dbusSel = `KS10_DBUS_SEL_DP;
         #1;
         checkWord("select dp", dp.word, dbus.word);
      end
   endtask

   task automatic testRamfile();
      logic [0:35] words [0:7];
      logic [2:0]  blocks [0:7];
      logic [0:35] r;
      // Distinct AC numbers keep the addresses apart
      for (int i = 0; i < 8; i++)
      begin
         r = randWord();
         blocks[i] = r[0:2];
         words[i] = randWord();
         writeFm(blocks[i], 4'(i), words[i]);
      end
      for (int i = 0; i < 8; i++)
      begin
         @(negedge clk);
         crom.fmAddrSel = 1'b0;
         crom.acBlock = blocks[i];
         crom.acNum = 4'(i);
         crom.dbusSel = `KS10_DBUS_SEL_RAMFILE;
         #1;
         checkWord("ramfile read", words[i], dbus.word);
      end
   endtask

   task automatic testVmaTiming();
      logic [0:35]  w;
      logic [0:35]  f;
      logic [14:35] expAddr;
      vmaFlagsT     expFlags;
      // Nothing loaded since reset
      expAddr = '0;
      expFlags = '0;
      for (int i = 0; i < 4; i++)
      begin
         w = randWord();
         f = randWord();
         @(negedge clk);
         dp.word = w;
         crom.vmaFlagsIn = vmaFlagsT'(f[0:13]);
         crom.loadVma = 1'b1;
         #1;
         // Still the old value before the edge
         checkWord("vma before edge", {14'd0, expAddr}, {14'd0, vmaAddr});
         checkWord("flags before edge", {22'd0, expFlags}, {22'd0, vmaFlags});
         @(posedge clk);
         #1;
         checkWord("vma after edge", {14'd0, w[14:35]}, {14'd0, vmaAddr});
         checkWord("flags after edge", {22'd0, f[0:13]}, {22'd0, vmaFlags});
         @(negedge clk);
         crom.loadVma = 1'b0;
         dp.word = randWord();
         crom.vmaFlagsIn = vmaFlagsT'(~f[0:13]);
         repeat (2) @(posedge clk);
         #1;
         checkWord("vma hold", {14'd0, w[14:35]}, {14'd0, vmaAddr});
         checkWord("flags hold", {22'd0, f[0:13]}, {22'd0, vmaFlags});
         expAddr = w[14:35];
         expFlags = vmaFlagsT'(f[0:13]);
      end
   endtask

   task automatic testDbm();
      logic [0:35]  w;
      logic [0:35]  expv;
      logic [14:35] vAddr;
      vmaFlagsT     flags;
      w = randWord();
      vAddr = w[14:35];
      flags = vmaFlagsT'(w[0:13]);
      // No read cycle, so DBM is never overridden
      flags.readCycle = 1'b0;
      loadVmaReg(vAddr, flags);
      @(negedge clk);
      scad.word = randWord();
      bytes.word = randWord();
      exp.word = randWord();
      dp.word = randWord();
      memData.word = randWord();
      w = randWord();
      crom.number = w[18:35];
      crom.dbusSel = `KS10_DBUS_SEL_DBM;
      for (int s = 0; s < 8; s++)
      begin
         @(negedge clk);
         crom.dbmSel = 3'(s);
         #1;
         case (crom.dbmSel)
            `KS10_DBM_SEL_SCADPFAR: expv = {scad.word[0:17], vAddr[18:35]};
            `KS10_DBM_SEL_BYTES:    expv = bytes.word;
            `KS10_DBM_SEL_EXP:      expv = exp.word;
            `KS10_DBM_SEL_DP:       expv = dp.word;
            `KS10_DBM_SEL_DPSWAP:   expv = {dp.word[18:35], dp.word[0:17]};
            `KS10_DBM_SEL_VMA:      expv = {flags, vAddr};
            `KS10_DBM_SEL_MEM:      expv = memData.word;
            default:                expv = {crom.number, crom.number};
         endcase
         checkWord($sformatf("dbm sel %0d", s), expv, dbus.word);
      end
   endtask

   // DBM from memory, ramfile word expected only if the override applies
   task automatic forceCase(input string name, input logic [14:35] addr,
                            input vmaFlagsT flags, input logic [0:11] uAddr,
                            input logic hit, input logic useRam,
                            input logic [0:35] ramWord);
      logic [0:35] expv;
      loadVmaReg(addr, flags);
      @(negedge clk);
      memData.word = randWord();
      crom.microAddr = uAddr;
      cacheHit = hit;
      crom.fmAddrSel = 1'b1;
      crom.dbusSel = `KS10_DBUS_SEL_DBM;
      crom.dbmSel = `KS10_DBM_SEL_MEM;
      #1;
      expv = useRam ? ramWord : memData.word;
      checkWord(name, expv, dbus.word);
      @(negedge clk);
      cacheHit = 1'b0;
      crom.microAddr = '0;
   endtask

   task automatic testForceRamfile();
      logic [0:35]  acWord;
      logic [0:35]  hitWord;
      logic [14:35] acAddr;
      logic [14:35] highAddr;
      logic [14:35] farAddr;
      vmaFlagsT     rd;
      vmaFlagsT     phys;
      vmaFlagsT     noRd;
      acWord = randWord();
      hitWord = randWord();
      // AC 7 sits at ramfile word 7, block 3 AC 5 at 0x185
      writeFm(3'd0, 4'd7, acWord);
      writeFm(3'd3, 4'd5, hitWord);
      acAddr = '0;
      acAddr[14:17] = 4'b1010;
      acAddr[32:35] = 4'd7;
      highAddr = acAddr;
      highAddr[25] = 1'b1;
      farAddr = '0;
      farAddr[20] = 1'b1;
      farAddr[26:35] = 10'b0110000101;
      rd = '0;
      rd.readCycle = 1'b1;
      phys = rd;
      phys.physical = 1'b1;
      noRd = '0;
      forceCase("force acref", acAddr, rd, 12'o0, 1'b0, 1'b1, acWord);
      forceCase("force acref other uaddr", acAddr, rd, 12'o1145, 1'b0, 1'b1, acWord);
      forceCase("force physical", acAddr, phys, 12'o0, 1'b0, 1'b0, acWord);
      forceCase("force high bits", highAddr, rd, 12'o0, 1'b0, 1'b0, acWord);
      forceCase("force no read", acAddr, noRd, 12'o0, 1'b0, 1'b0, acWord);
      forceCase("force excluded uaddr", acAddr, rd, `KS10_ACREF_EXCL_ADDR,
                1'b0, 1'b0, acWord);
      forceCase("force cache hit", farAddr, rd, 12'o0, 1'b1, 1'b1, hitWord);
      forceCase("force cache hit phys", farAddr, phys, 12'o0, 1'b1, 1'b1, hitWord);
      forceCase("force cache no read", farAddr, noRd, 12'o0, 1'b1, 1'b0, hitWord);
   endtask

   ////////////////////////////////////////////////////////////
   // Sequence and watchdog
   ////////////////////////////////////////////////////////////

   initial
   begin
      crom = '0;
      cacheHit = 1'b0;
      pcFlags = '0;
      dp = '0;
      memData = '0;
      scad = '0;
      bytes = '0;
      exp = '0;
      arstN = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      arstN = 1'b1;
      testResetSelects();
      testRamfile();
      testVmaTiming();
      testDbm();
      testForceRamfile();
      @(negedge clk);
      $display("Tests complete with %0d errors", errors);
      if (errors == 0)
      begin
         $display("All tests passed");
      end
      else
      begin
         $display("Some tests failed");
      end
      $finish;
   end

   initial
   begin
      #(testCycles * clkPeriod + marginNs);
      $display("Timeout, the tests did not finish in time");
      $display("Some tests failed");
      $finish;
   end

endmodule
